//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcd_dsptc -f sources.f \
	-o tb_dcd_dsptc > build.log 2>&1 \
	&& ./obj_dir/tb_dcd_dsptc +verilator+error+limit+100 > sim.log 2>&1 \
	|| { echo "build or simulation stopped with an error"; cat build.log; }
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log 2>/dev/null && echo "PASS" && exit 0 \
	|| { echo "FAIL"; exit 1; }

//--- sources.f
src/dcd_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/reg_read_stage.sv
src/dispatcher.sv
src/dcd_dsptc_top.sv
testbench/dcd_dsptc_assert.sv
testbench/tb_dcd_dsptc.sv

//--- src/dcd_dsptc_top.sv
`timescale 1ns/1ps

module dcd_dsptc_top #(
	parameter int xlen = 32
) (
	input  logic clk,
	input  logic rst_n,
	input  logic flush,
	input  dcd_pkg::fetch_t fetch,
	input  logic fetch_valid,
	output logic fetch_ready,
	input  logic wb_en,
	input  logic [4:0] wb_addr,
	input  logic [xlen-1:0] wb_data,
	output dcd_pkg::alu_req_t alu_req,
	output logic alu_valid,
	input  logic alu_ready,
	output dcd_pkg::lsu_req_t lsu_req,
	output logic lsu_valid,
	input  logic lsu_ready,
	output dcd_pkg::mul_req_t mul_req,
	output logic mul_valid,
	input  logic mul_ready
);
	import dcd_pkg::*;

	dcd_t dcd;
	logic dcd_valid;
	logic dcd_ready;
	dsp_t dsp;
	logic dsp_valid;
	logic dsp_ready;
	logic [4:0] rs1_addr;
	logic [4:0] rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;

	inst_decoder u_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.fetch(fetch),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.dcd(dcd),
		.dcd_valid(dcd_valid),
		.dcd_ready(dcd_ready)
	);

	reg_file #(
		.xlen(xlen)
	) u_reg_file (
		.clk(clk),
		.rst_n(rst_n),
		.rd_addr0(rs1_addr),
		.rd_data0(rs1_data),
		.rd_addr1(rs2_addr),
		.rd_data1(rs2_data),
		.wr_en(wb_en),
		.wr_addr(wb_addr),
		.wr_data(wb_data)
	);

	reg_read_stage #(
		.xlen(xlen)
	) u_reg_read (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.dcd(dcd),
		.dcd_valid(dcd_valid),
		.dcd_ready(dcd_ready),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.dsp(dsp),
		.dsp_valid(dsp_valid),
		.dsp_ready(dsp_ready)
	);

	dispatcher u_dispatcher (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.dsp(dsp),
		.dsp_valid(dsp_valid),
		.dsp_ready(dsp_ready),
		.alu_req(alu_req),
		.alu_valid(alu_valid),
		.alu_ready(alu_ready),
		.lsu_req(lsu_req),
		.lsu_valid(lsu_valid),
		.lsu_ready(lsu_ready),
		.mul_req(mul_req),
		.mul_valid(mul_valid),
		.mul_ready(mul_ready)
	);

endmodule

//--- src/dcd_pkg.sv
package dcd_pkg;

	localparam int dflt_xlen = 32; // data path width the records are built for
	localparam int msg_w = 3 * dflt_xlen + 4; // lsu message is the widest member

	typedef enum logic [1:0] {
		unit_alu = 2'd0,
		unit_lsu = 2'd1,
		unit_mul = 2'd2
	} unit_e;

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_slt  = 4'd5,
		alu_sltu = 4'd6,
		alu_sll  = 4'd7,
		alu_srl  = 4'd8,
		alu_sra  = 4'd9
	} alu_op_e;

	typedef struct packed {
		logic [dflt_xlen-1:0] pc;
		logic [31:0] inst;
	} fetch_t;

	typedef struct packed {
		logic [dflt_xlen-1:0] pc;
		logic [4:0] rs1;
		logic rs1_need;
		logic [4:0] rs2;
		logic rs2_need;
		logic [4:0] rd;
		logic rd_wr;
		logic [dflt_xlen-1:0] imm;
		unit_e unit;
		alu_op_e alu_op;
		logic use_imm; // op2 from imm instead of rs2
		logic ls_sel; // 0 load, 1 store
		logic [2:0] ls_type; // funct3 of the access
		logic mul_high; // upper half of the product
		logic mul_uns; // zero-extend both operands
		logic illegal;
		logic [31:0] inst;
	} dcd_t;

	typedef struct packed {
		logic [msg_w-2*dflt_xlen-6:0] pad;
		alu_op_e op;
		logic [dflt_xlen-1:0] op1;
		logic [dflt_xlen-1:0] op2; // raw instruction when illegal
		logic illegal;
	} alu_msg_t;

	typedef struct packed {
		logic sel;
		logic [2:0] ls_type;
		logic [dflt_xlen-1:0] base;
		logic [dflt_xlen-1:0] ofs;
		logic [dflt_xlen-1:0] wdata;
	} lsu_msg_t;

	typedef struct packed {
		logic [msg_w-2*dflt_xlen-4:0] pad;
		logic [dflt_xlen:0] op_a;
		logic [dflt_xlen:0] op_b;
		logic res_sel; // 1 selects the high word
	} mul_msg_t;

	// one stored word, read according to the unit field
	typedef union packed {
		alu_msg_t alu;
		lsu_msg_t lsu;
		mul_msg_t mul;
	} dsp_msg_u;

	typedef struct packed {
		unit_e unit;
		logic [4:0] rd;
		logic rd_wr;
		logic [dflt_xlen-1:0] pc;
		dsp_msg_u msg;
	} dsp_t;

	typedef struct packed {
		logic [dflt_xlen-1:0] pc;
		logic [4:0] rd;
		alu_msg_t msg;
	} alu_req_t;

	typedef struct packed {
		logic [4:0] rd;
		lsu_msg_t msg;
	} lsu_req_t;

	typedef struct packed {
		logic [4:0] rd;
		mul_msg_t msg;
	} mul_req_t;

endpackage

//--- src/dispatcher.sv
`timescale 1ns/1ps

module dispatcher (
	input  logic clk,
	input  logic rst_n,
	input  logic flush,
	input  dcd_pkg::dsp_t dsp,
	input  logic dsp_valid,
	output logic dsp_ready,
	output dcd_pkg::alu_req_t alu_req,
	output logic alu_valid,
	input  logic alu_ready,
	output dcd_pkg::lsu_req_t lsu_req,
	output logic lsu_valid,
	input  logic lsu_ready,
	output dcd_pkg::mul_req_t mul_req,
	output logic mul_valid,
	input  logic mul_ready
);
	import dcd_pkg::*;

	dsp_t held;
	logic held_valid;
	logic sel_ready;
	logic [4:0] rd_out;

	// ready of the unit the held item targets
	always_comb begin
		case (held.unit)
			unit_lsu: sel_ready = lsu_ready;
			unit_mul: sel_ready = mul_ready;
			default: sel_ready = alu_ready;
		endcase
	end

	assign dsp_ready = !held_valid || sel_ready;
	assign rd_out = held.rd_wr ? held.rd : 5'd0; // x0 when nothing is written back

	assign alu_valid = held_valid && held.unit == unit_alu;
	assign lsu_valid = held_valid && held.unit == unit_lsu;
	assign mul_valid = held_valid && held.unit == unit_mul;

	assign alu_req = '{pc: held.pc, rd: rd_out, msg: held.msg.alu};
	assign lsu_req = '{rd: rd_out, msg: held.msg.lsu};
	assign mul_req = '{rd: rd_out, msg: held.msg.mul};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			held_valid <= 1'b0;
		else if (flush)
			held_valid <= 1'b0;
		else if (dsp_valid && dsp_ready)
			held_valid <= 1'b1;
		else if (sel_ready)
			held_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (dsp_valid && dsp_ready)
			held <= dsp;
	end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input  logic clk,
	input  logic rst_n,
	input  logic flush,
	input  dcd_pkg::fetch_t fetch,
	input  logic fetch_valid,
	output logic fetch_ready,
	output dcd_pkg::dcd_t dcd,
	output logic dcd_valid,
	input  logic dcd_ready
);
	import dcd_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	dcd_t nxt;

	function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: alu_op_of = alt ? alu_sub : alu_add;
			3'b001: alu_op_of = alu_sll;
			3'b010: alu_op_of = alu_slt;
			3'b011: alu_op_of = alu_sltu;
			3'b100: alu_op_of = alu_xor;
			3'b101: alu_op_of = alt ? alu_sra : alu_srl;
			3'b110: alu_op_of = alu_or;
			default: alu_op_of = alu_and;
		endcase
	endfunction

	assign opcode = fetch.inst[6:0];
	assign funct3 = fetch.inst[14:12];
	assign funct7 = fetch.inst[31:25];
	assign imm_i = {{20{fetch.inst[31]}}, fetch.inst[31:20]};
	assign imm_s = {{20{fetch.inst[31]}}, fetch.inst[31:25], fetch.inst[11:7]};

	always_comb begin
		nxt = '0;
		nxt.pc = fetch.pc;
		nxt.inst = fetch.inst;
		nxt.rs1 = fetch.inst[19:15];
		nxt.rs2 = fetch.inst[24:20];
		nxt.rd = fetch.inst[11:7];
		nxt.unit = unit_alu;
		nxt.alu_op = alu_add;
		nxt.ls_type = funct3;
		nxt.illegal = 1'b1; // cleared by each supported encoding
		case (opcode)
			7'b0110011: begin // register ops and mul
				nxt.rs1_need = 1'b1;
				nxt.rs2_need = 1'b1;
				nxt.rd_wr = 1'b1;
				if (funct7 == 7'b0000001) begin
					nxt.unit = unit_mul;
					nxt.mul_high = funct3 != 3'b000;
					nxt.mul_uns = funct3 == 3'b011;
					nxt.illegal = !(funct3 inside {3'b000, 3'b001, 3'b011});
				end else begin
					nxt.alu_op = alu_op_of(funct3, funct7[5]);
					nxt.illegal = !(funct7 == 7'b0000000 ||
						(funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101}));
				end
			end
			7'b0010011: begin // immediate ops
				nxt.rs1_need = 1'b1;
				nxt.rd_wr = 1'b1;
				nxt.use_imm = 1'b1;
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					nxt.imm = {27'd0, fetch.inst[24:20]}; // shamt only
					nxt.alu_op = alu_op_of(funct3, funct7[5]);
					nxt.illegal = !(funct7 == 7'b0000000 ||
						(funct7 == 7'b0100000 && funct3 == 3'b101));
				end else begin
					nxt.imm = imm_i;
					nxt.alu_op = alu_op_of(funct3, 1'b0);
					nxt.illegal = 1'b0;
				end
			end
			7'b0110111: begin // lui adds the upper imm to x0
				nxt.rd_wr = 1'b1;
				nxt.use_imm = 1'b1;
				nxt.imm = {fetch.inst[31:12], 12'd0};
				nxt.illegal = 1'b0;
			end
			7'b0000011: begin
				nxt.unit = unit_lsu;
				nxt.rs1_need = 1'b1;
				nxt.rd_wr = 1'b1;
				nxt.imm = imm_i;
				nxt.illegal = !(funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
			end
			7'b0100011: begin
				nxt.unit = unit_lsu;
				nxt.ls_sel = 1'b1;
				nxt.rs1_need = 1'b1;
				nxt.rs2_need = 1'b1;
				nxt.imm = imm_s;
				nxt.illegal = !(funct3 inside {3'b000, 3'b001, 3'b010});
			end
			default: nxt.illegal = 1'b1;
		endcase
		if (nxt.illegal) begin
			// goes to the alu as a plain word
			nxt.unit = unit_alu;
			nxt.rs1_need = 1'b0;
			nxt.rs2_need = 1'b0;
			nxt.rd_wr = 1'b0;
			nxt.use_imm = 1'b0;
		end
	end

	assign fetch_ready = !dcd_valid || dcd_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dcd_valid <= 1'b0;
		else if (flush)
			dcd_valid <= 1'b0;
		else if (fetch_valid && fetch_ready)
			dcd_valid <= 1'b1;
		else if (dcd_ready)
			dcd_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (fetch_valid && fetch_ready)
			dcd <= nxt;
	end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
	parameter int xlen = 32
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [4:0] rd_addr0,
	output logic [xlen-1:0] rd_data0,
	input  logic [4:0] rd_addr1,
	output logic [xlen-1:0] rd_data1,
	input  logic wr_en,
	input  logic [4:0] wr_addr,
	input  logic [xlen-1:0] wr_data
);

	logic [xlen-1:0] regs [0:31];

	// x0 is cleared at reset and never written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd_data0 = regs[rd_addr0]; // no write forwarding
	assign rd_data1 = regs[rd_addr1];

endmodule

//--- src/reg_read_stage.sv
`timescale 1ns/1ps

module reg_read_stage #(
	parameter int xlen = 32
) (
	input  logic clk,
	input  logic rst_n,
	input  logic flush,
	input  dcd_pkg::dcd_t dcd,
	input  logic dcd_valid,
	output logic dcd_ready,
	output logic [4:0] rs1_addr,
	output logic [4:0] rs2_addr,
	input  logic [xlen-1:0] rs1_data,
	input  logic [xlen-1:0] rs2_data,
	output dcd_pkg::dsp_t dsp,
	output logic dsp_valid,
	input  logic dsp_ready
);
	import dcd_pkg::*;

	logic [xlen-1:0] op2;
	dsp_t nxt;

	// unused sources read x0
	assign rs1_addr = dcd.rs1_need ? dcd.rs1 : 5'd0;
	assign rs2_addr = dcd.rs2_need ? dcd.rs2 : 5'd0;
	assign op2 = dcd.use_imm ? dcd.imm : rs2_data;

	always_comb begin
		nxt = '0;
		nxt.unit = dcd.unit;
		nxt.rd = dcd.rd;
		nxt.rd_wr = dcd.rd_wr;
		nxt.pc = dcd.pc;
		case (dcd.unit)
			unit_lsu: begin
				nxt.msg.lsu.sel = dcd.ls_sel;
				nxt.msg.lsu.ls_type = dcd.ls_type;
				nxt.msg.lsu.base = rs1_data;
				nxt.msg.lsu.ofs = dcd.imm;
				nxt.msg.lsu.wdata = rs2_data;
			end
			unit_mul: begin
				nxt.msg.mul.op_a = {!dcd.mul_uns && rs1_data[xlen-1], rs1_data};
				nxt.msg.mul.op_b = {!dcd.mul_uns && rs2_data[xlen-1], rs2_data};
				nxt.msg.mul.res_sel = dcd.mul_high;
			end
			default: begin
				nxt.msg.alu.op = dcd.alu_op;
				nxt.msg.alu.op1 = rs1_data;
				nxt.msg.alu.op2 = dcd.illegal ? xlen'(dcd.inst) : op2; // raw word on illegal
				nxt.msg.alu.illegal = dcd.illegal;
			end
		endcase
	end

	assign dcd_ready = !dsp_valid || dsp_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dsp_valid <= 1'b0;
		else if (flush)
			dsp_valid <= 1'b0;
		else if (dcd_valid && dcd_ready)
			dsp_valid <= 1'b1;
		else if (dsp_ready)
			dsp_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (dcd_valid && dcd_ready)
			dsp <= nxt;
	end

endmodule

//--- testbench/dcd_dsptc_assert.sv
`timescale 1ns/1ps

module dcd_dsptc_assert (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic alu_valid,
	input logic alu_ready,
	input dcd_pkg::alu_req_t alu_req,
	input logic lsu_valid,
	input logic lsu_ready,
	input dcd_pkg::lsu_req_t lsu_req,
	input logic mul_valid,
	input logic mul_ready,
	input dcd_pkg::mul_req_t mul_req
);

	int fail_cnt = 0; // read by the testbench at the end

	one_unit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({alu_valid, lsu_valid, mul_valid}))
	else begin
		fail_cnt++;
		$error("more than one unit valid");
	end

	alu_hold: assert property (@(posedge clk) disable iff (!rst_n)
		alu_valid && !alu_ready && !flush |=> alu_valid && $stable(alu_req))
	else begin
		fail_cnt++;
		$error("alu request changed under stall");
	end

	lsu_hold: assert property (@(posedge clk) disable iff (!rst_n)
		lsu_valid && !lsu_ready && !flush |=> lsu_valid && $stable(lsu_req))
	else begin
		fail_cnt++;
		$error("lsu request changed under stall");
	end

	mul_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mul_valid && !mul_ready && !flush |=> mul_valid && $stable(mul_req))
	else begin
		fail_cnt++;
		$error("mul request changed under stall");
	end

	// flush empties the dispatcher on the next edge
	flush_clear: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> !(alu_valid || lsu_valid || mul_valid))
	else begin
		fail_cnt++;
		$error("unit valid in the cycle after flush");
	end

endmodule

//--- testbench/tb_dcd_dsptc.sv
`timescale 1ns/1ps

module tb_dcd_dsptc;
	import dcd_pkg::*;

	localparam int xlen = 32;
	localparam int stream_len = 60;

	typedef struct packed {
		logic [1:0] unit;
		logic [31:0] pc;
		logic [4:0] rd;
		logic rd_chk; // rd is written back
		logic op_chk; // op and op1 are defined
		logic [3:0] alu_op;
		logic [31:0] op1; // lsu base
		logic [31:0] op2; // lsu store data
		logic illegal;
		logic ls_sel;
		logic [2:0] ls_type;
		logic [31:0] ofs;
		logic wd_chk;
		logic [32:0] mul_a;
		logic [32:0] mul_b;
		logic mul_hi;
	} exp_t;

	logic clk = 1'b0;
	logic rst_n;
	logic flush;
	fetch_t fetch;
	logic fetch_valid;
	logic fetch_ready;
	logic wb_en;
	logic [4:0] wb_addr;
	logic [xlen-1:0] wb_data;
	alu_req_t alu_req;
	logic alu_valid;
	logic alu_ready = 1'b1;
	lsu_req_t lsu_req;
	logic lsu_valid;
	logic lsu_ready = 1'b1;
	mul_req_t mul_req;
	logic mul_valid;
	logic mul_ready = 1'b1;

	logic [31:0] seed = 32'h5155_5773;
	logic [31:0] model_rf [32];
	logic [31:0] pc_next = 32'h0000_1000;
	logic [31:0] stream [stream_len];
	exp_t exp_q [$];
	int ready_mode = 0; // 0 all ready, 1 random, 2 none
	int cyc = 0;
	int fetch_cyc;
	int xfer_cyc;
	int errors = 0;
	int got_cnt = 0;
	int err_mark;
	int got_mark;
	int ntests = 0;

	dcd_dsptc_top #(
		.xlen(xlen)
	) dut (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.fetch(fetch),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.alu_req(alu_req),
		.alu_valid(alu_valid),
		.alu_ready(alu_ready),
		.lsu_req(lsu_req),
		.lsu_valid(lsu_valid),
		.lsu_ready(lsu_ready),
		.mul_req(mul_req),
		.mul_valid(mul_valid),
		.mul_ready(mul_ready)
	);

	bind dispatcher dcd_dsptc_assert u_assert (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.alu_valid(alu_valid),
		.alu_ready(alu_ready),
		.alu_req(alu_req),
		.lsu_valid(lsu_valid),
		.lsu_ready(lsu_ready),
		.lsu_req(lsu_req),
		.mul_valid(mul_valid),
		.mul_ready(mul_ready),
		.mul_req(mul_req)
	);

	always #20 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [31:0] lcg();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	// kind 0 alu reg, 1 alu imm, 2 lui, 3 load, 4 store, 5 mul
	function automatic logic [31:0] rand_inst(input int kind);
		logic [31:0] r;
		logic [31:0] s;
		logic [2:0] f3;
		logic [6:0] f7;
		r = lcg();
		s = lcg();
		f3 = s[30:28];
		f7 = ((f3 == 3'd0 || f3 == 3'd5) && s[27]) ? 7'h20 : 7'h00;
		case (kind)
			0: rand_inst = {f7, r[24:20], r[19:15], f3, r[11:7], 7'h33};
			1: begin
				if (f3 == 3'd1 || f3 == 3'd5)
					rand_inst = {f3 == 3'd5 ? f7 : 7'h00, r[24:20], r[19:15], f3, r[11:7], 7'h13};
				else
					rand_inst = {r[31:20], r[19:15], f3, r[11:7], 7'h13};
			end
			2: rand_inst = {r[31:12], r[11:7], 7'h37};
			3: begin
				f3 = s[29:27] % 3'd5;
				if (f3 == 3'd3)
					f3 = 3'd5; // lb lh lw lbu lhu
				rand_inst = {r[31:20], r[19:15], f3, r[11:7], 7'h03};
			end
			4: begin
				f3 = s[29:27] % 3'd3;
				rand_inst = {r[31:25], r[24:20], r[19:15], f3, r[11:7], 7'h23};
			end
			default: begin
				f3 = s[28:27] == 2'd2 ? 3'd3 : {1'b0, s[28:27]}; // mul mulh mulhu
				rand_inst = {7'h01, r[24:20], r[19:15], f3, r[11:7], 7'h33};
			end
		endcase
	endfunction

	function automatic logic [3:0] alu_code(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return alt ? alu_sub : alu_add;
			3'd1: return alu_sll;
			3'd2: return alu_slt;
			3'd3: return alu_sltu;
			3'd4: return alu_xor;
			3'd5: return alt ? alu_sra : alu_srl;
			3'd6: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	// expected dispatch of one instruction given the register contents
	function automatic exp_t ref_model(input logic [31:0] inst, input logic [31:0] pc,
			input logic [31:0] rf [32]);
		exp_t e;
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic shift;
		logic ok;
		opc = inst[6:0];
		f3 = inst[14:12];
		f7 = inst[31:25];
		a = rf[inst[19:15]];
		b = rf[inst[24:20]];
		imm = {{20{inst[31]}}, inst[31:20]};
		shift = f3 == 3'd1 || f3 == 3'd5;
		e = '0;
		e.pc = pc;
		e.rd = inst[11:7];
		e.rd_chk = 1'b1;
		e.op_chk = 1'b1;
		e.unit = unit_alu;
		ok = 1'b0;
		case (opc)
			7'h33, 7'h13: begin
				if (opc == 7'h33 && f7 == 7'h01) begin
					ok = f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd3;
					e.unit = unit_mul;
					e.mul_a = {f3 != 3'd3 && a[31], a}; // mulhu zero-extends
					e.mul_b = {f3 != 3'd3 && b[31], b};
					e.mul_hi = f3 != 3'd0;
				end else if (opc == 7'h13 && !shift) begin
					ok = 1'b1;
					e.alu_op = alu_code(f3, 1'b0);
					e.op1 = a;
					e.op2 = imm;
				end else begin
					ok = f7 == 7'h00 ||
						(f7 == 7'h20 && (f3 == 3'd5 || (f3 == 3'd0 && opc == 7'h33)));
					e.alu_op = alu_code(f3, f7[5]);
					e.op1 = a;
					e.op2 = opc == 7'h33 ? b : {27'd0, inst[24:20]};
				end
			end
			7'h37: begin
				ok = 1'b1;
				e.alu_op = alu_add; // x0 plus upper immediate
				e.op1 = '0;
				e.op2 = {inst[31:12], 12'd0};
			end
			7'h03: begin
				ok = f3 != 3'd3 && f3 < 3'd6;
				e.unit = unit_lsu;
				e.ls_type = f3;
				e.op1 = a;
				e.ofs = imm;
			end
			7'h23: begin
				ok = f3 < 3'd3;
				e.unit = unit_lsu;
				e.ls_sel = 1'b1;
				e.ls_type = f3;
				e.op1 = a;
				e.ofs = {{20{inst[31]}}, inst[31:25], inst[11:7]};
				e.op2 = b;
				e.wd_chk = 1'b1;
				e.rd_chk = 1'b0;
			end
			default: ok = 1'b0;
		endcase
		if (!ok) begin
			e.unit = unit_alu;
			e.illegal = 1'b1;
			e.op2 = inst;
			e.op_chk = 1'b0;
			e.rd_chk = 1'b0;
		end
		return e;
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	always @(negedge clk) begin : drive_readies
		logic [31:0] r;
		if (ready_mode == 1) begin
			r = lcg();
			alu_ready = r[31] | r[28];
			lsu_ready = r[30] | r[27];
			mul_ready = r[29] | r[26];
		end else begin
			alu_ready = ready_mode == 0;
			lsu_ready = ready_mode == 0;
			mul_ready = ready_mode == 0;
		end
	end

	// compares every unit transfer with the oldest expected item
	always @(posedge clk) begin : monitor
		exp_t e;
		if (rst_n && ((alu_valid && alu_ready) || (lsu_valid && lsu_ready) ||
				(mul_valid && mul_ready))) begin
			got_cnt++; // every unit transfer
			if (exp_q.size() == 0) begin
				$display("Unit transfer at cycle %0d with no instruction outstanding", cyc);
				errors++;
			end else begin
				e = exp_q.pop_front();
				xfer_cyc = cyc;
				if (alu_valid) begin
					check("unit", unit_alu, e.unit);
					check("alu_req.pc", alu_req.pc, e.pc);
					check("alu_req.msg.op2", alu_req.msg.op2, e.op2);
					check("alu_req.msg.illegal", alu_req.msg.illegal, e.illegal);
					if (e.op_chk) begin
						check("alu_req.msg.op", alu_req.msg.op, e.alu_op);
						check("alu_req.msg.op1", alu_req.msg.op1, e.op1);
					end
					if (e.rd_chk)
						check("alu_req.rd", alu_req.rd, e.rd);
				end else if (lsu_valid) begin
					check("unit", unit_lsu, e.unit);
					check("lsu_req.msg.sel", lsu_req.msg.sel, e.ls_sel);
					check("lsu_req.msg.ls_type", lsu_req.msg.ls_type, e.ls_type);
					check("lsu_req.msg.base", lsu_req.msg.base, e.op1);
					check("lsu_req.msg.ofs", lsu_req.msg.ofs, e.ofs);
					if (e.wd_chk)
						check("lsu_req.msg.wdata", lsu_req.msg.wdata, e.op2);
					if (e.rd_chk)
						check("lsu_req.rd", lsu_req.rd, e.rd);
				end else begin
					check("unit", unit_mul, e.unit);
					check("mul_req.msg.op_a", mul_req.msg.op_a, e.mul_a);
					check("mul_req.msg.op_b", mul_req.msg.op_b, e.mul_b);
					check("mul_req.msg.res_sel", mul_req.msg.res_sel, e.mul_hi);
					check("mul_req.rd", mul_req.rd, e.rd);
				end
			end
		end
	end

	// called on a falling edge, returns on the falling edge after the transfer
	task automatic issue(input logic [31:0] inst);
		int t;
		logic accepted;
		exp_q.push_back(ref_model(inst, pc_next, model_rf));
		fetch.pc = pc_next;
		fetch.inst = inst;
		fetch_valid = 1'b1;
		accepted = 1'b0;
		for (t = 0; t < 200 && !accepted; t++) begin
			@(posedge clk);
			accepted = fetch_ready;
		end
		fetch_cyc = cyc;
		@(negedge clk);
		fetch_valid = 1'b0;
		pc_next += 4;
		if (!accepted) begin
			$display("Timeout: fetch_ready stayed low for 200 cycles");
			errors++;
		end
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		wb_en = 1'b1;
		wb_addr = addr;
		wb_data = data;
		@(negedge clk);
		wb_en = 1'b0;
		if (addr != 5'd0)
			model_rf[addr] = data;
	endtask

	task automatic set_ready_mode(input int mode);
		@(posedge clk);
		ready_mode = mode;
		@(negedge clk);
	endtask

	task automatic wait_drain(input string name);
		int t;
		for (t = 0; t < 500 && exp_q.size() != 0; t++)
			@(negedge clk);
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d instructions of %s never reached a unit", exp_q.size(), name);
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic start_test();
		err_mark = errors;
		got_mark = got_cnt;
	endtask

	task automatic end_test(input string name);
		ntests++;
		$display("%-10s %0d instructions, %0d errors", name, got_cnt - got_mark,
			errors - err_mark);
	endtask

	initial begin
		rst_n = 1'b0;
		flush = 1'b0;
		fetch = '0;
		fetch_valid = 1'b0;
		wb_en = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		for (int i = 0; i < 32; i++)
			model_rf[i] = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		write_reg(5'd0, 32'hdead_beef); // x0 must stay zero
		for (int i = 1; i < 32; i++)
			write_reg(i[4:0], lcg());
		@(negedge clk);

		start_test();
		issue(r_type(7'h00, 5'd7, 5'd0, 3'd0, 5'd5, 7'h33));
		issue(r_type(7'h00, 5'd0, 5'd0, 3'd6, 5'd8, 7'h33));
		issue({12'h005, 5'd0, 3'd0, 5'd6, 7'h13});
		for (int i = 0; i < 40; i++)
			issue(rand_inst(i % 3));
		wait_drain("alu_ops");
		end_test("alu_ops");

		start_test();
		for (int i = 0; i < 30; i++)
			issue(rand_inst(3 + i % 2));
		wait_drain("lsu_ops");
		end_test("lsu_ops");

		start_test();
		for (int i = 0; i < 30; i++)
			issue(rand_inst(5));
		wait_drain("mul_ops");
		end_test("mul_ops");

		start_test();
		issue(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, 7'h63)); // beq
		issue(r_type(7'h01, 5'd2, 5'd1, 3'd4, 5'd3, 7'h33)); // div
		issue(r_type(7'h01, 5'd2, 5'd1, 3'd2, 5'd3, 7'h33)); // mulhsu
		issue(32'h0080_00ef);
		issue(32'h3401_1073);
		issue(r_type(7'h20, 5'd3, 5'd1, 3'd1, 5'd4, 7'h13));
		issue(r_type(7'h00, 5'd4, 5'd1, 3'd3, 5'd5, 7'h03));
		issue(r_type(7'h00, 5'd4, 5'd1, 3'd4, 5'd5, 7'h23));
		issue(32'h0000_0000);
		wait_drain("illegal");
		end_test("illegal");

		start_test();
		issue(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));
		wait_drain("latency");
		check("latency", xfer_cyc - fetch_cyc, 3);
		end_test("latency");

		start_test();
		for (int i = 0; i < stream_len; i++)
			stream[i] = rand_inst(lcg() % 6);
		set_ready_mode(1);
		for (int i = 0; i < stream_len; i++)
			issue(stream[i]);
		wait_drain("stream");
		set_ready_mode(0);
		check("instructions delivered", got_cnt - got_mark, stream_len);
		end_test("stream");

		start_test();
		set_ready_mode(2);
		for (int i = 0; i < 3; i++)
			issue(rand_inst(lcg() % 6));
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		exp_q.delete(); // flushed items are gone
		set_ready_mode(0);
		for (int i = 0; i < 10; i++)
			issue(rand_inst(lcg() % 6));
		wait_drain("flush");
		check("instructions delivered", got_cnt - got_mark, 10);
		end_test("flush");

		repeat (5) @(negedge clk);
		$display("%0d tests, %0d instructions, %0d errors, %0d assertion failures", ntests,
			got_cnt, errors, dut.u_dispatcher.u_assert.fail_cnt);
		if (errors == 0 && dut.u_dispatcher.u_assert.fail_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
